//--- common/issue_pkg.sv
// Issue stage shared definitions
package issue_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    parameter int XLEN       = 32;
    parameter int REG_IDX_W  = 5;
    parameter int NUM_REGS   = 32;
    parameter int INSTR_STEP = 4;

    // Register index fields inside the opcode
    parameter int RD_LSB = 7;
    parameter int RA_LSB = 15;
    parameter int RB_LSB = 20;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // ----------------------------------------
    // Signal groups
    // ----------------------------------------
    typedef struct packed {
        logic  valid;
        word_t instr;
        word_t pc;
        logic  exec;
        logic  lsu;
        logic  branch;
        logic  mul;
        logic  rd_valid;
    } fetch_word_t;

    typedef struct packed {
        logic  request;
        word_t pc;
    } redirect_t;

    typedef struct packed {
        word_t    opcode;
        word_t    pc;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    ra_operand;
        word_t    rb_operand;
    } issue_op_t;

    // rd is zero for an instruction with no register result
    typedef struct packed {
        logic     valid;
        logic     load;
        logic     mul;
        reg_idx_t rd;
        word_t    result;
    } stage_info_t;

    typedef enum logic [1:0] {
        STAGE_E1 = 2'd0,
        STAGE_E2 = 2'd1,
        STAGE_WB = 2'd2
    } pipe_stage_e;

endpackage

//--- issue/fetch_align.sv
// Expected PC and slot alignment
`timescale 1ns/10ps

module fetch_align
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  issue_pkg::fetch_word_t fetch0_i
    ,input  issue_pkg::fetch_word_t fetch1_i
    ,input  issue_pkg::redirect_t   redirect0_i
    ,input  issue_pkg::redirect_t   redirect1_i
    ,input  logic [1:0]             issued_count_i

    ,output issue_pkg::fetch_word_t slot0_o
    ,output issue_pkg::fetch_word_t slot1_o
    ,output logic                   sel_word1_o
    ,output logic                   branch_request_o
    ,output issue_pkg::word_t       branch_pc_o
);

issue_pkg::word_t pc_q;
issue_pkg::word_t pc_step;

assign pc_step = issue_pkg::word_t'(issued_count_i) * issue_pkg::word_t'(issue_pkg::INSTR_STEP);

// Pipe 1 holds the younger branch, so its correction wins
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
        pc_q <= '0;
    else if (redirect1_i.request)
        pc_q <= redirect1_i.pc;
    else if (redirect0_i.request)
        pc_q <= redirect0_i.pc;
    else
        pc_q <= pc_q + pc_step;
end

always_comb
begin
    slot0_o          = '0;
    slot1_o          = '0;
    sel_word1_o      = 1'b0;
    branch_request_o = 1'b0;

    if (fetch0_i.valid && fetch0_i.pc == pc_q)
    begin
        slot0_o = fetch0_i;
        slot1_o = fetch1_i;
    end
    // Word 0 skipped, word 1 moves to the first slot
    else if (fetch1_i.valid && fetch1_i.pc == pc_q)
    begin
        slot0_o     = fetch1_i;
        sel_word1_o = 1'b1;
    end
    // Nothing at the expected PC
    else if (fetch0_i.valid || fetch1_i.valid)
        branch_request_o = 1'b1;
end

assign branch_pc_o = pc_q;

endmodule

//--- issue/issue_sched.sv
// Scoreboard and dual-issue scheduler
`timescale 1ns/10ps

module issue_sched
#(
     parameter int LOAD_BYPASS = 1
    ,parameter int MUL_BYPASS  = 1
)
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  issue_pkg::fetch_word_t slot0_i
    ,input  issue_pkg::fetch_word_t slot1_i
    ,input  logic                   sel_word1_i
    ,input  logic                   lsu_stall_i
    ,input  issue_pkg::stage_info_t e1_0_i
    ,input  issue_pkg::stage_info_t e1_1_i
    ,input  issue_pkg::stage_info_t e2_0_i
    ,input  issue_pkg::stage_info_t e2_1_i

    ,output logic                   issue0_o
    ,output logic                   issue1_o
    ,output logic                   fetch0_accept_o
    ,output logic                   fetch1_accept_o
    ,output logic                   route_lsu1_o
    ,output logic                   route_mul1_o
    ,output logic                   lsu_valid_o
    ,output logic                   mul_valid_o
    ,output logic [1:0]             issued_count_o
);

issue_pkg::reg_idx_t ra0, rb0, rd0;
issue_pkg::reg_idx_t ra1, rb1, rd1;
logic [issue_pkg::NUM_REGS-1:0] sb;
logic pair_ok;

assign ra0 = slot0_i.instr[issue_pkg::RA_LSB +: issue_pkg::REG_IDX_W];
assign rb0 = slot0_i.instr[issue_pkg::RB_LSB +: issue_pkg::REG_IDX_W];
assign rd0 = slot0_i.instr[issue_pkg::RD_LSB +: issue_pkg::REG_IDX_W];
assign ra1 = slot1_i.instr[issue_pkg::RA_LSB +: issue_pkg::REG_IDX_W];
assign rb1 = slot1_i.instr[issue_pkg::RB_LSB +: issue_pkg::REG_IDX_W];
assign rd1 = slot1_i.instr[issue_pkg::RD_LSB +: issue_pkg::REG_IDX_W];

// Which class pairs the second pipe can take
assign pair_ok =
    ((slot0_i.exec | slot0_i.lsu | slot0_i.mul) & (slot1_i.exec | slot1_i.branch)) |
    ((slot0_i.exec | slot0_i.mul) & slot1_i.lsu) |
    ((slot0_i.exec | slot0_i.lsu) & slot1_i.mul);

always_comb
begin
    sb = '0;

    // Results not ready in E1
    if (e1_0_i.load || e1_0_i.mul)
        sb[e1_0_i.rd] = 1'b1;
    if (e1_1_i.load || e1_1_i.mul)
        sb[e1_1_i.rd] = 1'b1;

    // E2 results that cannot be forwarded
    if (LOAD_BYPASS == 0)
    begin
        if (e2_0_i.load)
            sb[e2_0_i.rd] = 1'b1;
        if (e2_1_i.load)
            sb[e2_1_i.rd] = 1'b1;
    end
    if (MUL_BYPASS == 0)
    begin
        if (e2_0_i.mul)
            sb[e2_0_i.rd] = 1'b1;
        if (e2_1_i.mul)
            sb[e2_1_i.rd] = 1'b1;
    end
    sb[0] = 1'b0;

    issue0_o = slot0_i.valid && !lsu_stall_i && !(sb[ra0] || sb[rb0] || sb[rd0]);

    // Slot 1 may not use what slot 0 writes this cycle
    if (issue0_o && slot0_i.rd_valid && rd0 != '0)
        sb[rd0] = 1'b1;

    issue1_o = issue0_o && pair_ok && slot1_i.valid && !(sb[ra1] || sb[rb1] || sb[rd1]);
end

// A word-1-only selection drops word 0 along with the issue
assign fetch0_accept_o = issue0_o;
assign fetch1_accept_o = sel_word1_i ? issue0_o : issue1_o;

assign route_lsu1_o = issue1_o & slot1_i.lsu;
assign route_mul1_o = issue1_o & slot1_i.mul;
assign lsu_valid_o  = route_lsu1_o | (issue0_o & slot0_i.lsu);
assign mul_valid_o  = route_mul1_o | (issue0_o & slot0_i.mul);

assign issued_count_o = {1'b0, issue0_o} + {1'b0, issue1_o};

// ----------------------------------------
// Checks
// ----------------------------------------
assert property (@(posedge clk_i) disable iff (rst_i) issue1_o |-> issue0_o);

assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_stall_i |-> !(fetch0_accept_o || fetch1_accept_o));

endmodule

//--- issue/operand_bypass.sv
// Operand forwarding for one issue slot
`timescale 1ns/10ps

module operand_bypass
(
     input  issue_pkg::fetch_word_t slot_i
    ,input  issue_pkg::word_t       rf_ra_i
    ,input  issue_pkg::word_t       rf_rb_i
    ,input  issue_pkg::stage_info_t e1_0_i
    ,input  issue_pkg::stage_info_t e1_1_i
    ,input  issue_pkg::stage_info_t e2_0_i
    ,input  issue_pkg::stage_info_t e2_1_i
    ,input  issue_pkg::stage_info_t wb_0_i
    ,input  issue_pkg::stage_info_t wb_1_i
    ,input  issue_pkg::word_t       alu0_result_i
    ,input  issue_pkg::word_t       alu1_result_i

    ,output issue_pkg::issue_op_t   op_o
);

// Oldest source first so the newest one lands last
function automatic issue_pkg::word_t pick(input issue_pkg::reg_idx_t idx,
                                          input issue_pkg::word_t rf_val);
    issue_pkg::word_t val;
    val = rf_val;
    if (wb_0_i.rd == idx)
        val = wb_0_i.result;
    if (wb_1_i.rd == idx)
        val = wb_1_i.result;
    if (e2_0_i.rd == idx)
        val = e2_0_i.result;
    if (e2_1_i.rd == idx)
        val = e2_1_i.result;
    if (e1_0_i.rd == idx)
        val = alu0_result_i;
    if (e1_1_i.rd == idx)
        val = alu1_result_i;
    // x0 is hardwired
    if (idx == '0)
        val = '0;
    return val;
endfunction

always_comb
begin
    op_o.opcode     = slot_i.instr;
    op_o.pc         = slot_i.pc;
    op_o.rd         = slot_i.instr[issue_pkg::RD_LSB +: issue_pkg::REG_IDX_W];
    op_o.ra         = slot_i.instr[issue_pkg::RA_LSB +: issue_pkg::REG_IDX_W];
    op_o.rb         = slot_i.instr[issue_pkg::RB_LSB +: issue_pkg::REG_IDX_W];
    op_o.ra_operand = pick(op_o.ra, rf_ra_i);
    op_o.rb_operand = pick(op_o.rb, rf_rb_i);
end

endmodule

//--- pipe/pipe_tracker.sv
// Pipe occupancy tracker for E1, E2 and WB
`timescale 1ns/10ps

module pipe_tracker
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  logic                   issue_i
    ,input  issue_pkg::fetch_word_t slot_i
    ,input  issue_pkg::word_t       alu_result_i
    ,input  issue_pkg::word_t       mem_result_i
    ,input  issue_pkg::word_t       mul_result_i

    ,output issue_pkg::stage_info_t e1_o
    ,output issue_pkg::stage_info_t e2_o
    ,output issue_pkg::stage_info_t wb_o
);

issue_pkg::stage_info_t stage_q [3];
issue_pkg::stage_info_t e1_next;
logic                   writes_rd;

assign writes_rd = issue_i & slot_i.rd_valid;

// Decoded entry for E1
always_comb
begin
    e1_next.valid  = issue_i;
    e1_next.load   = writes_rd & slot_i.lsu;
    e1_next.mul    = issue_i & slot_i.mul;
    e1_next.rd     = writes_rd ? slot_i.instr[issue_pkg::RD_LSB +: issue_pkg::REG_IDX_W] : '0;
    e1_next.result = '0;
end

// The pipe never stalls
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        stage_q[issue_pkg::STAGE_E1] <= '0;
        stage_q[issue_pkg::STAGE_E2] <= '0;
        stage_q[issue_pkg::STAGE_WB] <= '0;
    end
    else
    begin
        stage_q[issue_pkg::STAGE_E1] <= e1_next;
        stage_q[issue_pkg::STAGE_E2] <= e1_o;
        stage_q[issue_pkg::STAGE_WB] <= e2_o;
    end
end

// ALU value arrives in E1, memory and multiply in E2
always_comb
begin
    e1_o        = stage_q[issue_pkg::STAGE_E1];
    e1_o.result = alu_result_i;

    e2_o = stage_q[issue_pkg::STAGE_E2];
    if (e2_o.load)
        e2_o.result = mem_result_i;
    else if (e2_o.mul)
        e2_o.result = mul_result_i;
end

assign wb_o = stage_q[issue_pkg::STAGE_WB];

// A register destination never rides in an empty stage
assert property (@(posedge clk_i) disable iff (rst_i)
    ((e1_o.rd == '0) || e1_o.valid) &&
    ((e2_o.rd == '0) || e2_o.valid) &&
    ((wb_o.rd == '0) || wb_o.valid));

endmodule

//--- src/regfile.sv
// Two-write four-read register file
`timescale 1ns/10ps

module regfile
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  issue_pkg::stage_info_t wr0_i
    ,input  issue_pkg::stage_info_t wr1_i
    ,input  issue_pkg::reg_idx_t    ra0_i
    ,input  issue_pkg::reg_idx_t    rb0_i
    ,input  issue_pkg::reg_idx_t    ra1_i
    ,input  issue_pkg::reg_idx_t    rb1_i

    ,output issue_pkg::word_t       ra0_value_o
    ,output issue_pkg::word_t       rb0_value_o
    ,output issue_pkg::word_t       ra1_value_o
    ,output issue_pkg::word_t       rb1_value_o
);

issue_pkg::word_t regs_q [issue_pkg::NUM_REGS];

// Entry 0 is never written and stays zero
always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        for (int i = 0; i < issue_pkg::NUM_REGS; i++)
            regs_q[i] <= '0;
    end
    else
    begin
        for (int i = 1; i < issue_pkg::NUM_REGS; i++)
        begin
            // Pipe 1 is the younger write
            if (wr1_i.valid && wr1_i.rd == issue_pkg::reg_idx_t'(i))
                regs_q[i] <= wr1_i.result;
            else if (wr0_i.valid && wr0_i.rd == issue_pkg::reg_idx_t'(i))
                regs_q[i] <= wr0_i.result;
        end
    end
end

assign ra0_value_o = regs_q[ra0_i];
assign rb0_value_o = regs_q[rb0_i];
assign ra1_value_o = regs_q[ra1_i];
assign rb1_value_o = regs_q[rb1_i];

endmodule

//--- src/issue_stage.sv
// Dual-issue stage top level
`timescale 1ns/10ps

module issue_stage
#(
     parameter int LOAD_BYPASS = 1
    ,parameter int MUL_BYPASS  = 1
)
(
     input  logic                   clk_i
    ,input  logic                   rst_i
    ,input  issue_pkg::fetch_word_t fetch0_i
    ,input  issue_pkg::fetch_word_t fetch1_i
    ,input  issue_pkg::redirect_t   redirect0_i
    ,input  issue_pkg::redirect_t   redirect1_i
    ,input  issue_pkg::word_t       alu0_result_i
    ,input  issue_pkg::word_t       alu1_result_i
    ,input  issue_pkg::word_t       mem_result_i
    ,input  issue_pkg::word_t       mul_result_i
    ,input  logic                   lsu_stall_i

    ,output logic                   fetch0_accept_o
    ,output logic                   fetch1_accept_o
    ,output logic                   branch_request_o
    ,output issue_pkg::word_t       branch_pc_o
    ,output logic                   exec0_valid_o
    ,output logic                   exec1_valid_o
    ,output logic                   lsu_valid_o
    ,output logic                   mul_valid_o
    ,output issue_pkg::issue_op_t   issue0_o
    ,output issue_pkg::issue_op_t   issue1_o
    ,output issue_pkg::issue_op_t   lsu_op_o
    ,output issue_pkg::issue_op_t   mul_op_o
);

issue_pkg::fetch_word_t slot0;
issue_pkg::fetch_word_t slot1;
logic                   sel_word1;
logic [1:0]             issued_count;
logic                   issue0;
logic                   issue1;
logic                   route_lsu1;
logic                   route_mul1;

issue_pkg::stage_info_t e1_0, e2_0, wb_0;
issue_pkg::stage_info_t e1_1, e2_1, wb_1;
issue_pkg::word_t       rf_ra0, rf_rb0, rf_ra1, rf_rb1;

// ----------------------------------------
// Slot selection and scheduling
// ----------------------------------------
fetch_align u_fetch_align
(
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.fetch0_i(fetch0_i)
    ,.fetch1_i(fetch1_i)
    ,.redirect0_i(redirect0_i)
    ,.redirect1_i(redirect1_i)
    ,.issued_count_i(issued_count)
    ,.slot0_o(slot0)
    ,.slot1_o(slot1)
    ,.sel_word1_o(sel_word1)
    ,.branch_request_o(branch_request_o)
    ,.branch_pc_o(branch_pc_o)
);

issue_sched
#(
     .LOAD_BYPASS(LOAD_BYPASS)
    ,.MUL_BYPASS(MUL_BYPASS)
)
u_sched
(
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.slot0_i(slot0)
    ,.slot1_i(slot1)
    ,.sel_word1_i(sel_word1)
    ,.lsu_stall_i(lsu_stall_i)
    ,.e1_0_i(e1_0)
    ,.e1_1_i(e1_1)
    ,.e2_0_i(e2_0)
    ,.e2_1_i(e2_1)
    ,.issue0_o(issue0)
    ,.issue1_o(issue1)
    ,.fetch0_accept_o(fetch0_accept_o)
    ,.fetch1_accept_o(fetch1_accept_o)
    ,.route_lsu1_o(route_lsu1)
    ,.route_mul1_o(route_mul1)
    ,.lsu_valid_o(lsu_valid_o)
    ,.mul_valid_o(mul_valid_o)
    ,.issued_count_o(issued_count)
);

assign exec0_valid_o = issue0;
assign exec1_valid_o = issue1;

// ----------------------------------------
// Pipe tracking
// ----------------------------------------
pipe_tracker u_pipe0
(
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.issue_i(issue0)
    ,.slot_i(slot0)
    ,.alu_result_i(alu0_result_i)
    ,.mem_result_i(mem_result_i)
    ,.mul_result_i(mul_result_i)
    ,.e1_o(e1_0)
    ,.e2_o(e2_0)
    ,.wb_o(wb_0)
);

pipe_tracker u_pipe1
(
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.issue_i(issue1)
    ,.slot_i(slot1)
    ,.alu_result_i(alu1_result_i)
    ,.mem_result_i(mem_result_i)
    ,.mul_result_i(mul_result_i)
    ,.e1_o(e1_1)
    ,.e2_o(e2_1)
    ,.wb_o(wb_1)
);

// ----------------------------------------
// Register file and operands
// ----------------------------------------
regfile u_regfile
(
     .clk_i(clk_i)
    ,.rst_i(rst_i)
    ,.wr0_i(wb_0)
    ,.wr1_i(wb_1)
    ,.ra0_i(slot0.instr[issue_pkg::RA_LSB +: issue_pkg::REG_IDX_W])
    ,.rb0_i(slot0.instr[issue_pkg::RB_LSB +: issue_pkg::REG_IDX_W])
    ,.ra1_i(slot1.instr[issue_pkg::RA_LSB +: issue_pkg::REG_IDX_W])
    ,.rb1_i(slot1.instr[issue_pkg::RB_LSB +: issue_pkg::REG_IDX_W])
    ,.ra0_value_o(rf_ra0)
    ,.rb0_value_o(rf_rb0)
    ,.ra1_value_o(rf_ra1)
    ,.rb1_value_o(rf_rb1)
);

operand_bypass u_bypass0
(
     .slot_i(slot0)
    ,.rf_ra_i(rf_ra0)
    ,.rf_rb_i(rf_rb0)
    ,.e1_0_i(e1_0)
    ,.e1_1_i(e1_1)
    ,.e2_0_i(e2_0)
    ,.e2_1_i(e2_1)
    ,.wb_0_i(wb_0)
    ,.wb_1_i(wb_1)
    ,.alu0_result_i(alu0_result_i)
    ,.alu1_result_i(alu1_result_i)
    ,.op_o(issue0_o)
);

operand_bypass u_bypass1
(
     .slot_i(slot1)
    ,.rf_ra_i(rf_ra1)
    ,.rf_rb_i(rf_rb1)
    ,.e1_0_i(e1_0)
    ,.e1_1_i(e1_1)
    ,.e2_0_i(e2_0)
    ,.e2_1_i(e2_1)
    ,.wb_0_i(wb_0)
    ,.wb_1_i(wb_1)
    ,.alu0_result_i(alu0_result_i)
    ,.alu1_result_i(alu1_result_i)
    ,.op_o(issue1_o)
);

// Shared units take whichever slot carries their operation
assign lsu_op_o = route_lsu1 ? issue1_o : issue0_o;
assign mul_op_o = route_mul1 ? issue1_o : issue0_o;

endmodule

//--- tb/issue_stage_tb.sv
// Issue stage testbench
`timescale 1ns/10ps

module issue_stage_tb;

localparam logic [3:0] CL_NONE = 4'b0000;
localparam logic [3:0] CL_EX   = 4'b1000;
localparam logic [3:0] CL_LS   = 4'b0100;
localparam logic [3:0] CL_BR   = 4'b0010;
localparam logic [3:0] CL_MU   = 4'b0001;
localparam logic [31:0] REDIRECT_PC = 32'h200;

typedef struct {
    logic       v0, v1;
    logic [3:0] c0, c1;
    int         rd0, ra0, rb0, rd1, ra1, rb1;
    logic       bad_pc, stall, redir;
    logic       e0, e1, ebr;
    int         src;
} row_t;

logic clk_i, rst_i, lsu_stall_i;
issue_pkg::fetch_word_t fetch0_i, fetch1_i;
issue_pkg::redirect_t   redirect0_i, redirect1_i;
issue_pkg::word_t       alu0_result_i, alu1_result_i, mem_result_i, mul_result_i;
logic fetch0_accept_o, fetch1_accept_o, branch_request_o;
logic exec0_valid_o, exec1_valid_o, lsu_valid_o, mul_valid_o;
issue_pkg::word_t     branch_pc_o;
issue_pkg::issue_op_t issue0_o, issue1_o, lsu_op_o, mul_op_o;

row_t        rows[$];
logic [31:0] alu_hist[$];
logic [31:0] lcg_state;
logic [31:0] exp_pc;
int          errors;
int          checks;
int          cycles;

issue_stage #(.LOAD_BYPASS(1), .MUL_BYPASS(1)) issue_stage_i (.*);

initial
begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
end

// ----------------------------------------
// Helpers
// ----------------------------------------
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

function automatic issue_pkg::fetch_word_t make_word(input logic v, input logic [3:0] cls,
    input int rd, input int ra, input int rb, input logic [31:0] pc);
    issue_pkg::fetch_word_t w;
    w          = '0;
    w.valid    = v;
    w.instr    = (32'(rb) << 20) | (32'(ra) << 15) | (32'(rd) << 7) | 32'h13;
    w.pc       = pc;
    {w.exec, w.lsu, w.branch, w.mul} = cls;
    w.rd_valid = cls[3] | cls[2] | cls[0];
    return w;
endfunction

task automatic add_row(input logic v0, input logic v1, input logic [3:0] c0,
    input logic [3:0] c1, input int rd0, input int ra0, input int rb0, input int rd1,
    input int ra1, input int rb1, input logic bad_pc, input logic stall, input logic redir,
    input logic e0, input logic e1, input logic ebr, input int src);
    row_t r;
    r = '{v0, v1, c0, c1, rd0, ra0, rb0, rd1, ra1, rb1, bad_pc, stall, redir,
          e0, e1, ebr, src};
    rows.push_back(r);
endtask

task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
        errors++;
        $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
endtask

// ----------------------------------------
// Stimulus table
// ----------------------------------------
task automatic build_table();
    add_row(0, 0, CL_NONE, CL_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, -1);
    // Pairing rules at the expected PC
    add_row(1, 1, CL_EX, CL_EX, 1, 0, 0, 2, 0, 0, 0, 0, 0, 1, 1, 0, -1);
    add_row(1, 1, CL_EX, CL_BR, 1, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, -1);
    add_row(1, 1, CL_LS, CL_EX, 3, 0, 0, 4, 0, 0, 0, 0, 0, 1, 1, 0, -1);
    add_row(1, 1, CL_LS, CL_LS, 5, 0, 0, 6, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 1, CL_MU, CL_LS, 6, 0, 0, 7, 0, 0, 0, 0, 0, 1, 1, 0, -1);
    add_row(1, 1, CL_LS, CL_MU, 8, 0, 0, 9, 0, 0, 0, 0, 0, 1, 1, 0, -1);
    add_row(1, 1, CL_MU, CL_MU, 11, 0, 0, 19, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 1, CL_BR, CL_EX, 0, 0, 0, 26, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 1, CL_EX, CL_EX, 12, 0, 0, 27, 12, 0, 0, 0, 0, 1, 0, 0, -1);
    // Misprediction followed by a redirect
    add_row(1, 1, CL_EX, CL_EX, 1, 0, 0, 2, 0, 0, 1, 0, 0, 0, 0, 1, -1);
    add_row(0, 0, CL_NONE, CL_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 13, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    // Load hazard with dependent and independent readers
    add_row(1, 0, CL_LS, CL_NONE, 14, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 15, 14, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 15, 14, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 0, CL_LS, CL_NONE, 16, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 18, 17, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    // Forwarding from E1, E2, WB and the register file
    add_row(1, 0, CL_EX, CL_NONE, 10, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    for (int i = 0; i < 5; i++)
        add_row(1, 0, CL_EX, CL_NONE, 20 + i, 10, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 18);
    // Stall holds the instruction
    add_row(1, 0, CL_EX, CL_NONE, 25, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 25, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, -1);
    add_row(1, 0, CL_EX, CL_NONE, 25, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, -1);
    add_row(0, 0, CL_NONE, CL_NONE, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, -1);
endtask

// ----------------------------------------
// Main sequence
// ----------------------------------------
initial
begin
    row_t        r;
    logic [31:0] pc0;
    int          err_before;

    rst_i         = 1'b1;
    lsu_stall_i   = 1'b0;
    fetch0_i      = '0;
    fetch1_i      = '0;
    redirect0_i   = '0;
    redirect1_i   = '0;
    alu0_result_i = '0;
    alu1_result_i = '0;
    mem_result_i  = '0;
    mul_result_i  = '0;
    lcg_state     = 32'd28969;
    exp_pc        = '0;
    errors        = 0;
    checks        = 0;
    build_table();

    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    for (int n = 0; n < rows.size(); n++)
    begin
        r          = rows[n];
        err_before = errors;
        pc0        = r.bad_pc ? exp_pc + 32'h100 : exp_pc;
        @(posedge clk_i);
        alu_hist.push_back(lcg_next());
        alu0_result_i <= alu_hist[n];
        alu1_result_i <= lcg_next();
        fetch0_i      <= make_word(r.v0, r.c0, r.rd0, r.ra0, r.rb0, pc0);
        fetch1_i      <= make_word(r.v1, r.c1, r.rd1, r.ra1, r.rb1, pc0 + 32'd4);
        lsu_stall_i   <= r.stall;
        redirect0_i   <= '{request: r.redir, pc: REDIRECT_PC};
        @(negedge clk_i);

        compare(exec0_valid_o, r.e0, "exec0_valid_o");
        compare(exec1_valid_o, r.e1, "exec1_valid_o");
        compare(fetch0_accept_o, r.e0, "fetch0_accept_o");
        compare(fetch1_accept_o, r.e1, "fetch1_accept_o");
        compare(branch_request_o, r.ebr, "branch_request_o");
        if (r.ebr)
            compare(branch_pc_o, exp_pc, "branch_pc_o");
        if (r.e0)
            compare(issue0_o.pc, pc0, "issue0_o.pc");
        if (r.e1)
        begin
            compare(issue1_o.pc, pc0 + 32'd4, "issue1_o.pc");
            compare(issue1_o.rd, r.rd1, "issue1_o.rd");
        end
        // Shared units take slot 1 only when slot 1 carries their class
        if (r.e1 && r.c1 == CL_LS)
            compare(lsu_op_o.pc, pc0 + 32'd4, "lsu_op_o.pc");
        else if (r.e0 && r.c0 == CL_LS)
            compare(lsu_op_o.pc, pc0, "lsu_op_o.pc");
        if (r.e1 && r.c1 == CL_MU)
            compare(mul_op_o.pc, pc0 + 32'd4, "mul_op_o.pc");
        else if (r.e0 && r.c0 == CL_MU)
            compare(mul_op_o.pc, pc0, "mul_op_o.pc");
        compare(lsu_valid_o, (r.e0 && r.c0 == CL_LS) || (r.e1 && r.c1 == CL_LS), "lsu_valid_o");
        compare(mul_valid_o, (r.e0 && r.c0 == CL_MU) || (r.e1 && r.c1 == CL_MU), "mul_valid_o");
        if (r.src >= 0)
        begin
            // Writer reaches E1 one row after it issues
            compare(issue0_o.ra_operand, alu_hist[r.src + 1], "ra operand");
            compare(issue0_o.rb_operand, 32'h0, "x0 operand");
        end

        if (r.redir)
            exp_pc = REDIRECT_PC;
        else
            exp_pc = exp_pc + 32'd4 * (32'(r.e0) + 32'(r.e1));
        $display("Row %0d %s", n, (errors == err_before) ? "ok" : "mismatch");
    end

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
        $display("Test passed");
    else
        $display("Test failed");
    $finish;
end

// Run limit from the table length plus reset and margin
initial
begin
    cycles = 0;
    while (cycles <= rows.size() + 4 + 40)
    begin
        @(posedge clk_i);
        cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycles - 1);
    $display("Test failed");
    $finish;
end

endmodule

//--- issue_stage.f
common/issue_pkg.sv
issue/fetch_align.sv
issue/issue_sched.sv
issue/operand_bypass.sv
pipe/pipe_tracker.sv
src/regfile.sv
src/issue_stage.sv
tb/issue_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= issue_stage_tb
FLIST     ?= issue_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)
